// File: design/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ########################################
// Cache geometry
// ########################################

// Byte address width.
`define DC_ADDR_W 32

// Width of one data word, a multiple of 8.
`define DC_WORD_W 64

`define DC_LINE_WORDS 4  // Words per line, a power of two.

`define DC_LINES 64  // Lines in the direct-mapped array, a power of two.

`endif

// File: design/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    // ########################################
    // Address fields
    // ########################################
    localparam int BOFF_W  = $clog2(`DC_WORD_W / 8);  // Byte offset inside a word.
    localparam int WOFF_W  = $clog2(`DC_LINE_WORDS);
    localparam int INDEX_W = $clog2(`DC_LINES);
    localparam int TAG_W   = `DC_ADDR_W - INDEX_W - WOFF_W - BOFF_W;

    typedef logic [`DC_ADDR_W-1:0]     addr_t;
    typedef logic [`DC_WORD_W-1:0]     word_t;
    typedef logic [`DC_WORD_W/8-1:0]   strb_t;
    typedef logic [WOFF_W-1:0]         woff_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [TAG_W+INDEX_W-1:0]  laddr_t;  // Tag in the upper bits, index below.

    // Word 0 of a line sits in the lowest bits.
    typedef logic [`DC_LINE_WORDS*`DC_WORD_W-1:0] line_t;

    // ########################################
    // Miss controller
    // ########################################
    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WB,
        MS_FILL_REQ,
        MS_FILL_WAIT
    } miss_state_t;

endpackage

// File: design/dcache_line_ram.sv
`timescale 1ns/100ps

module dcache_line_ram #(
    parameter int  DEPTH     = 64,
    parameter type payload_t = logic
) (
    input  logic               CLK,
    input  bit                 we,
    input  dcache_pkg::index_t waddr,
    input  payload_t           wdata,
    input  dcache_pkg::index_t raddr,
    output payload_t           rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // The read port is asynchronous, so a lookup sees data written at the previous edge.
    assign rdata = mem[raddr];

endmodule

// File: design/dcache_decode.sv
`timescale 1ns/100ps

module dcache_decode (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  dcache_pkg::addr_t    req_addr,
    input  dcache_pkg::word_t    req_wdata,
    input  dcache_pkg::strb_t    req_wstrb,
    input  logic                 stall,
    output logic                 ready,
    output logic                 op_valid,
    output logic                 op_write,
    output dcache_pkg::tag_t     op_tag,
    output dcache_pkg::index_t   op_index,
    output dcache_pkg::woff_t    op_word,
    output dcache_pkg::word_t    op_wdata,
    output dcache_pkg::strb_t    op_wstrb
);
    import dcache_pkg::*;

    assign ready = ~stall;  // A new request is taken whenever the held one completes.

    always_ff @(posedge CLK) begin
        if (RST) begin
            op_valid <= 1'b0;
        end else if (!stall) begin
            op_valid <= req_valid;
        end
    end

    // The low BOFF_W address bits select a byte and are dropped here.
    always_ff @(posedge CLK) begin
        if (!stall && req_valid) begin
            op_write <= req_write;
            op_word  <= req_addr[BOFF_W +: WOFF_W];
            op_index <= req_addr[BOFF_W + WOFF_W +: INDEX_W];
            op_tag   <= req_addr[BOFF_W + WOFF_W + INDEX_W +: TAG_W];
            op_wdata <= req_wdata;
            op_wstrb <= req_wstrb;
        end
    end

endmodule

// File: design/dcache_execute.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_execute (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 op_valid,
    input  logic                 op_write,
    input  dcache_pkg::tag_t     op_tag,
    input  dcache_pkg::index_t   op_index,
    input  logic                 wb_done,
    input  logic                 fill_valid,
    output logic                 stall,
    output bit                   op_done,
    output logic                 fill_we,
    output logic                 wb_valid,
    output dcache_pkg::laddr_t   wb_addr,
    output logic                 fill_req_valid,
    output dcache_pkg::laddr_t   fill_addr
);
    import dcache_pkg::*;

    tag_t                 stored_tag;
    logic [`DC_LINES-1:0] valid_q;
    logic [`DC_LINES-1:0] dirty_q;
    miss_state_t          state_q;
    logic                 hit;
    logic                 miss;
    logic                 victim_dirty;

    dcache_line_ram #(
        .DEPTH     (`DC_LINES),
        .payload_t (tag_t)
    ) tag_ram_i (
        .CLK   (CLK),
        .we    (fill_we),
        .waddr (op_index),
        .wdata (op_tag),
        .raddr (op_index),
        .rdata (stored_tag)
    );

    // ########################################
    // Lookup
    // ########################################
    assign hit          = op_valid & valid_q[op_index] & (stored_tag == op_tag);
    assign miss         = op_valid & ~hit;
    assign victim_dirty = valid_q[op_index] & dirty_q[op_index];

    assign op_done = hit;
    assign stall   = miss;  // Decode holds the op until the refill makes it hit.

    // The tag read stays on the victim until the refill overwrites it.
    assign wb_addr   = {stored_tag, op_index};
    assign fill_addr = {op_tag, op_index};

    assign fill_req_valid = (state_q == MS_FILL_REQ);
    assign fill_we        = (state_q == MS_FILL_WAIT) & fill_valid;

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[op_index] <= 1'b1;
            dirty_q[op_index] <= 1'b0;
        end else if (hit && op_write) begin
            dirty_q[op_index] <= 1'b1;
        end
    end

    // ########################################
    // Miss controller
    // ########################################
    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q  <= MS_IDLE;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            case (state_q)
                MS_IDLE: begin
                    if (miss && victim_dirty) begin
                        state_q  <= MS_WB;
                        wb_valid <= 1'b1;  // Victim goes out before the fetch.
                    end else if (miss) begin
                        state_q <= MS_FILL_REQ;
                    end
                end
                MS_WB: begin
                    if (wb_done) begin
                        state_q <= MS_FILL_REQ;
                    end
                end
                MS_FILL_REQ: begin
                    state_q <= MS_FILL_WAIT;
                end
                MS_FILL_WAIT: begin
                    if (fill_valid) begin
                        state_q <= MS_IDLE;  // The op hits in the next cycle.
                    end
                end
                default: begin
                    state_q <= MS_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/dcache_result.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_result (
    input  logic                 CLK,
    input  dcache_pkg::index_t   op_index,
    input  dcache_pkg::woff_t    op_word,
    input  logic                 op_write,
    input  dcache_pkg::word_t    op_wdata,
    input  dcache_pkg::strb_t    op_wstrb,
    input  bit                   op_done,
    input  logic                 fill_we,
    input  dcache_pkg::line_t    fill_line,
    output dcache_pkg::word_t    rdata,
    output dcache_pkg::line_t    victim_line
);
    import dcache_pkg::*;

    localparam int WORD_W = $bits(word_t);

    line_t cur_line;
    line_t merged_line;
    line_t wr_line;
    word_t cur_word;
    word_t merged_word;
    logic  line_we;

    dcache_line_ram #(
        .DEPTH     (`DC_LINES),
        .payload_t (line_t)
    ) data_ram_i (
        .CLK   (CLK),
        .we    (line_we),
        .waddr (op_index),
        .wdata (wr_line),
        .raddr (op_index),
        .rdata (cur_line)
    );

    assign cur_word    = cur_line[op_word * WORD_W +: WORD_W];
    assign rdata       = cur_word;
    assign victim_line = cur_line;

    // ########################################
    // Store merge
    // ########################################
    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (op_wstrb[b]) begin
                merged_word[b*8 +: 8] = op_wdata[b*8 +: 8];
            end
        end
        merged_line = cur_line;
        merged_line[op_word * WORD_W +: WORD_W] = merged_word;
    end

    // A refill and a completing store never fall in the same cycle.
    assign line_we = fill_we | (op_done & op_write);
    assign wr_line = fill_we ? fill_line : merged_line;

endmodule

// File: design/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 req_valid,
    input  logic                 req_write,
    input  dcache_pkg::addr_t    req_addr,
    input  dcache_pkg::word_t    req_wdata,
    input  dcache_pkg::strb_t    req_wstrb,
    output logic                 ready,
    output bit                   resp_valid,
    output dcache_pkg::word_t    rdata,
    output logic                 wb_valid,
    output dcache_pkg::laddr_t   wb_addr,
    output dcache_pkg::line_t    wb_line,
    input  logic                 wb_done,
    output logic                 fill_req_valid,
    output dcache_pkg::laddr_t   fill_addr,
    input  logic                 fill_valid,
    input  dcache_pkg::line_t    fill_line
);
    import dcache_pkg::*;

    logic   stall;
    logic   op_valid;
    logic   op_write;
    tag_t   op_tag;
    index_t op_index;
    woff_t  op_word;
    word_t  op_wdata;
    strb_t  op_wstrb;
    logic   fill_we;

    dcache_decode decode_i (
        .CLK       (CLK),
        .RST       (RST),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .stall     (stall),
        .ready     (ready),
        .op_valid  (op_valid),
        .op_write  (op_write),
        .op_tag    (op_tag),
        .op_index  (op_index),
        .op_word   (op_word),
        .op_wdata  (op_wdata),
        .op_wstrb  (op_wstrb)
    );

    // The completion strobe of execute is the response strobe.
    dcache_execute execute_i (
        .CLK            (CLK),
        .RST            (RST),
        .op_valid       (op_valid),
        .op_write       (op_write),
        .op_tag         (op_tag),
        .op_index       (op_index),
        .wb_done        (wb_done),
        .fill_valid     (fill_valid),
        .stall          (stall),
        .op_done        (resp_valid),
        .fill_we        (fill_we),
        .wb_valid       (wb_valid),
        .wb_addr        (wb_addr),
        .fill_req_valid (fill_req_valid),
        .fill_addr      (fill_addr)
    );

    dcache_result result_i (
        .CLK         (CLK),
        .op_index    (op_index),
        .op_word     (op_word),
        .op_write    (op_write),
        .op_wdata    (op_wdata),
        .op_wstrb    (op_wstrb),
        .op_done     (resp_valid),
        .fill_we     (fill_we),
        .fill_line   (fill_line),
        .rdata       (rdata),
        .victim_line (wb_line)
    );

endmodule

// File: verification/dcache_assert.sv
`timescale 1ns/100ps

module dcache_assert (
    input logic CLK,
    input logic RST,
    input logic ready,
    input bit   resp_valid,
    input logic wb_valid,
    input logic fill_req_valid
);

    // ########################################
    // Miss protocol
    // ########################################
    wb_fill_excl: assert property (@(posedge CLK) disable iff (RST)
        !(wb_valid && fill_req_valid))
        else $error("wb_valid and fill_req_valid are high together");

    fill_req_pulse: assert property (@(posedge CLK) disable iff (RST)
        fill_req_valid |=> !fill_req_valid)
        else $error("fill_req_valid is high for two cycles in a row");

    resp_while_ready: assert property (@(posedge CLK) disable iff (RST)
        resp_valid |-> ready)
        else $error("resp_valid is high while ready is low");

    // The first cycle out of reset shows the idle state.
    reset_state: assert property (@(posedge CLK)
        $fell(RST) |-> ready && !resp_valid && !wb_valid && !fill_req_valid)
        else $error("cache is not idle after reset");

endmodule

bind dcache_top dcache_assert assert_i (
    .CLK            (CLK),
    .RST            (RST),
    .ready          (ready),
    .resp_valid     (resp_valid),
    .wb_valid       (wb_valid),
    .fill_req_valid (fill_req_valid)
);

// File: verification/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT = 200;

    logic   CLK;
    logic   RST;
    logic   req_valid;
    logic   req_write;
    addr_t  req_addr;
    word_t  req_wdata;
    strb_t  req_wstrb;
    logic   ready;
    bit     resp_valid;
    word_t  rdata;
    logic   wb_valid;
    laddr_t wb_addr;
    line_t  wb_line;
    logic   wb_done;
    logic   fill_req_valid;
    laddr_t fill_addr;
    logic   fill_valid;
    line_t  fill_line;

    word_t  shadow [addr_t];  // Latest stored word for each word address.
    line_t  l2_mem [laddr_t];
    bit     exp_write [$];
    word_t  exp_word [$];
    string  test_name;
    int     test_err0;
    int     errors;
    int     tests;
    int     fills;
    int     wbs;
    int     resps;
    laddr_t last_wb_addr;
    laddr_t acc_laddr;  // Line address of the most recently accepted request.
    bit     aborted;

    dcache_top dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // ########################################
    // Reference model
    // ########################################
    function automatic word_t init_word(addr_t wa);
        return {32'hC0DE_0000 ^ wa, wa * 32'h9E37_79B9};
    endfunction

    function automatic addr_t word_addr(addr_t a);
        return a & ~addr_t'((1 << BOFF_W) - 1);
    endfunction

    function automatic addr_t make_addr(int t, int i, int w);
        return {tag_t'(t), index_t'(i), woff_t'(w), {BOFF_W{1'b0}}};
    endfunction

    function automatic word_t ref_read(addr_t a);
        if (shadow.exists(word_addr(a))) begin
            return shadow[word_addr(a)];
        end
        return init_word(word_addr(a));
    endfunction

    function automatic line_t ref_line(laddr_t la);
        line_t l;
        for (int w = 0; w < 2**WOFF_W; w++) begin
            l[w*$bits(word_t) +: $bits(word_t)] = ref_read({la, woff_t'(w), {BOFF_W{1'b0}}});
        end
        return l;
    endfunction

    function automatic line_t l2_read(laddr_t la);
        line_t l;
        if (l2_mem.exists(la)) begin
            return l2_mem[la];
        end
        for (int w = 0; w < 2**WOFF_W; w++) begin
            l[w*$bits(word_t) +: $bits(word_t)] = init_word({la, woff_t'(w), {BOFF_W{1'b0}}});
        end
        return l;
    endfunction

    task automatic shadow_store(addr_t a, word_t d, strb_t s);
        word_t w;
        w = ref_read(a);
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        shadow[word_addr(a)] = w;
    endtask

    // ########################################
    // Checks
    // ########################################
    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_line(string name, line_t exp, line_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_laddr(string name, laddr_t exp, laddr_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // ########################################
    // Stimulus
    // ########################################
    task automatic send_req(bit write, addr_t a, word_t d, strb_t s);
        int cnt;
        cnt = 0;
        if (aborted) begin
            return;
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = a;
        req_wdata = d;
        req_wstrb = s;
        @(negedge CLK);
        while (!ready) begin
            if (cnt == TIMEOUT) begin
                $display("Timeout in %s: request to %h was never accepted", test_name, a);
                errors++;
                aborted = 1'b1;
                return;
            end
            cnt++;
            @(negedge CLK);
        end
        if (write) begin
            shadow_store(a, d, s);
        end
        acc_laddr = laddr_t'(a >> (BOFF_W + WOFF_W));
        exp_write.push_back(write);
        exp_word.push_back(write ? '0 : ref_read(a));
        @(posedge CLK);
        #10;
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        req_valid = 1'b0;
        while (exp_write.size() != 0 && !aborted) begin
            if (cnt == TIMEOUT) begin
                $display("Timeout in %s: %0d responses missing", test_name, exp_write.size());
                errors++;
                aborted = 1'b1;
            end else begin
                cnt++;
                @(negedge CLK);
            end
        end
        @(posedge CLK);
        #10;
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %0d errors", test_name, errors - test_err0);
    endtask

    // Compare process. Outputs are sampled mid-cycle.
    initial begin
        word_t exp_w;
        forever begin
            @(negedge CLK);
            if (resp_valid) begin
                resps++;
                if (exp_write.size() == 0) begin
                    $display("Response in %s arrived with no request pending", test_name);
                    errors++;
                end else begin
                    exp_w = exp_word.pop_front();
                    if (!exp_write.pop_front()) begin
                        check_word({test_name, " rdata"}, exp_w, rdata);
                    end
                end
            end
            if (wb_valid) begin
                check_line({test_name, " wb_line"}, ref_line(wb_addr), wb_line);
            end
        end
    end

    // The L2 model serves one transfer at a time.
    initial begin
        int    delay;
        bit    is_wb;
        line_t ln;
        wb_done    = 1'b0;
        fill_valid = 1'b0;
        fill_line  = '0;
        forever begin
            @(negedge CLK);
            if (wb_valid || fill_req_valid) begin
                delay = $urandom_range(8, 1);
                is_wb = wb_valid;
                ln    = '0;
                if (is_wb) begin
                    l2_mem[wb_addr] = wb_line;
                    last_wb_addr    = wb_addr;
                    wbs++;
                end else begin
                    check_laddr({test_name, " fill_addr"}, acc_laddr, fill_addr);
                    ln = l2_read(fill_addr);
                    fills++;
                end
                repeat (delay) @(posedge CLK);
                #10;
                wb_done    = is_wb;
                fill_valid = !is_wb;
                fill_line  = ln;
                @(posedge CLK);
                #10;
                wb_done    = 1'b0;
                fill_valid = 1'b0;
            end
        end
    end

    // ########################################
    // Test sequence
    // ########################################
    initial begin
        int f0;
        int w0;
        int r0;
        void'($urandom(45537));
        RST       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        repeat (4) @(posedge CLK);
        #10;
        RST = 1'b0;

        start_test("cold_load");
        f0 = fills;
        send_req(1'b0, make_addr(5, 3, 1), '0, '0);
        drain();
        check_count("cold_load fills", f0 + 1, fills);
        send_req(1'b0, make_addr(5, 3, 2), '0, '0);
        drain();
        check_count("cold_load second fills", f0 + 1, fills);
        end_test();

        start_test("store_merge");
        send_req(1'b1, make_addr(5, 3, 2), 64'h1122_3344_5566_7788, 8'b1010_0110);
        send_req(1'b0, make_addr(5, 3, 2), '0, '0);
        drain();
        end_test();

        start_test("dirty_evict");
        f0 = fills;
        w0 = wbs;
        send_req(1'b0, make_addr(6, 3, 0), '0, '0);
        drain();
        check_count("dirty_evict writebacks", w0 + 1, wbs);
        check_count("dirty_evict fills", f0 + 1, fills);
        check_laddr("dirty_evict wb_addr", {tag_t'(5), index_t'(3)}, last_wb_addr);
        end_test();

        start_test("clean_evict");
        f0 = fills;
        w0 = wbs;
        send_req(1'b0, make_addr(7, 3, 1), '0, '0);
        drain();
        check_count("clean_evict writebacks", w0, wbs);
        check_count("clean_evict fills", f0 + 1, fills);
        end_test();

        start_test("random_mix");
        r0 = resps;
        for (int n = 0; n < 300; n++) begin
            send_req(($urandom() & 1) != 0,
                     make_addr($urandom_range(7, 0), $urandom_range(3, 0), $urandom_range(3, 0)),
                     {$urandom(), $urandom()}, strb_t'($urandom()));
        end
        drain();
        check_count("random_mix responses", r0 + 300, resps);
        end_test();

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0 && !aborted) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+design
design/dcache_pkg.sv
design/dcache_line_ram.sv
design/dcache_decode.sv
design/dcache_execute.sv
design/dcache_result.sv
design/dcache_top.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
exit 0
